/* cpu_pkg.sv */
package cpu_pkg;

    // Data words, instruction words and pc values share one width
    typedef logic [15:0] word_t;
    typedef logic [3:0]  reg_addr_t;
    typedef logic [3:0]  opcode_t;
    typedef logic [2:0]  cond_t;
    // Flag bits are N, V, Z from high to low
    typedef logic [2:0]  flags_t;
    typedef logic [2:0]  alu_op_t;

    localparam opcode_t OP_ADD = 4'h0;
    localparam opcode_t OP_SUB = 4'h1;
    localparam opcode_t OP_XOR = 4'h2;
    localparam opcode_t OP_SLL = 4'h4;
    localparam opcode_t OP_SRA = 4'h5;
    localparam opcode_t OP_ROR = 4'h6;
    localparam opcode_t OP_LW  = 4'h8;
    localparam opcode_t OP_SW  = 4'h9;
    localparam opcode_t OP_LLB = 4'hA;
    localparam opcode_t OP_LHB = 4'hB;
    localparam opcode_t OP_B   = 4'hC;
    localparam opcode_t OP_BR  = 4'hD;
    localparam opcode_t OP_PCS = 4'hE;
    localparam opcode_t OP_HLT = 4'hF;

    // Branch conditions in instr[11:9]
    localparam cond_t C_NE = 3'd0;
    localparam cond_t C_EQ = 3'd1;
    localparam cond_t C_GT = 3'd2;
    localparam cond_t C_LT = 3'd3;
    localparam cond_t C_GE = 3'd4;
    localparam cond_t C_LE = 3'd5;
    localparam cond_t C_OV = 3'd6;
    localparam cond_t C_UN = 3'd7;

    localparam int FLAG_N = 2;
    localparam int FLAG_V = 1;
    localparam int FLAG_Z = 0;

    localparam alu_op_t ALU_ADD  = 3'd0;
    localparam alu_op_t ALU_SUB  = 3'd1;
    localparam alu_op_t ALU_XOR  = 3'd2;
    localparam alu_op_t ALU_SLL  = 3'd3;
    localparam alu_op_t ALU_SRA  = 3'd4;
    localparam alu_op_t ALU_ROR  = 3'd5;
    localparam alu_op_t ALU_PASS = 3'd6;

endpackage

/* cpu_fetch.sv */
`timescale 1ns/1ps

module cpu_fetch import cpu_pkg::*; (
    input  logic   clk,
    input  logic   arst_n,
    input  word_t  instr,
    input  flags_t flags,
    input  word_t  br_target,
    output word_t  pc,
    output word_t  pc_plus2,
    output logic   hlt
);

    opcode_t opcode;
    cond_t   cond;
    logic    taken;
    word_t   b_offset;
    word_t   b_target;
    word_t   next_pc;

    assign opcode = instr[15:12];
    assign cond   = instr[11:9];
    assign hlt    = (opcode == OP_HLT);

    assign pc_plus2 = pc + 16'd2;

    // Signed 9-bit word offset, doubled into a byte offset
    assign b_offset = {{6{instr[8]}}, instr[8:0], 1'b0};
    assign b_target = pc_plus2 + b_offset;

    // Branch condition against the current flags
    always_comb begin
        case (cond)
            C_NE:    taken = !flags[FLAG_Z];
            C_EQ:    taken = flags[FLAG_Z];
            C_GT:    taken = !flags[FLAG_Z] && !flags[FLAG_N];
            C_LT:    taken = flags[FLAG_N];
            C_GE:    taken = flags[FLAG_Z] || !flags[FLAG_N];
            C_LE:    taken = flags[FLAG_N] || flags[FLAG_Z];
            C_OV:    taken = flags[FLAG_V];
            default: taken = 1'b1;
        endcase
    end

    always_comb begin
        if (opcode == OP_B && taken) begin
            next_pc = b_target;
        end else if (opcode == OP_BR && taken) begin
            next_pc = br_target;
        end else begin
            next_pc = pc_plus2;
        end
    end

    // HLT freezes the pc until the next reset
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= '0;
        end else if (!hlt) begin
            pc <= next_pc;
        end
    end

    // Register targets come from the register file, so an odd value there shows up here
    a_pc_even: assert property (
        @(posedge clk) disable iff (!arst_n) pc[0] == 1'b0
    ) else $error("pc is odd: %h", pc);

endmodule

/* cpu_decode.sv */
`timescale 1ns/1ps

module cpu_decode import cpu_pkg::*; (
    input  logic      clk,
    input  logic      arst_n,
    input  word_t     instr,
    input  word_t     wr_data,
    output word_t     src_a,
    output word_t     src_b,
    output word_t     imm,
    output alu_op_t   alu_op,
    output logic      alu_use_imm,
    output logic      flag_write,
    output logic      mem_read,
    output logic      mem_write,
    output logic      reg_write,
    output logic      wb_from_pc,
    output reg_addr_t dst
);

    opcode_t   opcode;
    reg_addr_t rs_sel;
    reg_addr_t rt_sel;
    logic      rd_as_a;
    logic      rd_as_b;
    logic      reg_write_raw;
    logic      mem_write_raw;
    word_t     regs [16];

    assign opcode = instr[15:12];
    assign dst    = instr[11:8];

    always_comb begin
        alu_op        = ALU_PASS;
        alu_use_imm   = 1'b0;
        flag_write    = 1'b0;
        mem_read      = 1'b0;
        mem_write_raw = 1'b0;
        reg_write_raw = 1'b0;
        wb_from_pc    = 1'b0;
        rd_as_a       = 1'b0;
        rd_as_b       = 1'b0;
        case (opcode)
            OP_ADD, OP_SUB, OP_XOR: begin
                alu_op        = (opcode == OP_ADD) ? ALU_ADD :
                                (opcode == OP_SUB) ? ALU_SUB : ALU_XOR;
                flag_write    = 1'b1;
                reg_write_raw = 1'b1;
            end
            OP_SLL, OP_SRA, OP_ROR: begin
                alu_op        = (opcode == OP_SLL) ? ALU_SLL :
                                (opcode == OP_SRA) ? ALU_SRA : ALU_ROR;
                alu_use_imm   = 1'b1;
                flag_write    = 1'b1;
                reg_write_raw = 1'b1;
            end
            OP_LW: begin
                alu_op        = ALU_ADD;
                alu_use_imm   = 1'b1;
                mem_read      = 1'b1;
                reg_write_raw = 1'b1;
            end
            OP_SW: begin
                alu_op        = ALU_ADD;
                alu_use_imm   = 1'b1;
                mem_write_raw = 1'b1;
                // Store data comes from rd
                rd_as_b       = 1'b1;
            end
            OP_LLB, OP_LHB: begin
                alu_use_imm   = 1'b1;
                reg_write_raw = 1'b1;
                rd_as_a       = 1'b1;
            end
            OP_PCS: begin
                reg_write_raw = 1'b1;
                wb_from_pc    = 1'b1;
            end
            // Opcodes 3 and 7, branches and HLT change no state here
            default: begin
            end
        endcase
    end

    // No register or memory write while the core is in reset
    assign reg_write = reg_write_raw && arst_n;
    assign mem_write = mem_write_raw && arst_n;

    assign rs_sel = rd_as_a ? dst : instr[7:4];
    assign rt_sel = rd_as_b ? dst : instr[3:0];

    assign src_a = regs[rs_sel];
    assign src_b = regs[rt_sel];

    always_comb begin
        case (opcode)
            // Byte loads keep the other byte of rd
            OP_LLB:  imm = {src_a[15:8], instr[7:0]};
            OP_LHB:  imm = {instr[7:0], src_a[7:0]};
            // Signed word offset, doubled for byte addressing
            OP_LW, OP_SW: imm = {{11{instr[3]}}, instr[3:0], 1'b0};
            default: imm = {12'h000, instr[3:0]};
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 16; i++) begin
                regs[i] <= '0;
            end
        end else if (reg_write) begin
            regs[dst] <= wr_data;
        end
    end

endmodule

/* cpu_alu.sv */
`timescale 1ns/1ps

module cpu_alu import cpu_pkg::*; (
    input  logic    clk,
    input  logic    arst_n,
    input  word_t   a,
    input  word_t   b,
    input  alu_op_t op,
    input  logic    flag_write,
    input  logic    kind_arith,
    output word_t   result,
    output flags_t  flags
);

    localparam word_t SAT_POS = 16'h7FFF;
    localparam word_t SAT_NEG = 16'h8000;

    word_t       sum;
    word_t       diff;
    logic        add_ovf;
    logic        sub_ovf;
    logic        sat;
    logic [3:0]  shamt;
    logic [31:0] rot;

    assign sum   = a + b;
    assign diff  = a - b;
    assign shamt = b[3:0];
    assign rot   = {a, a} >> shamt;

    // The sign of a picks the saturation rail on signed overflow
    assign add_ovf = (a[15] == b[15]) && (sum[15] != a[15]);
    assign sub_ovf = (a[15] != b[15]) && (diff[15] != a[15]);

    // Address adds for LW and SW wrap while ADD and SUB saturate
    always_comb begin
        sat    = 1'b0;
        result = b;
        case (op)
            ALU_ADD: begin
                sat    = kind_arith && add_ovf;
                result = sat ? (a[15] ? SAT_NEG : SAT_POS) : sum;
            end
            ALU_SUB: begin
                sat    = kind_arith && sub_ovf;
                result = sat ? (a[15] ? SAT_NEG : SAT_POS) : diff;
            end
            ALU_XOR: result = a ^ b;
            ALU_SLL: result = a << shamt;
            ALU_SRA: result = word_t'($signed(a) >>> shamt);
            ALU_ROR: result = rot[15:0];
            default: result = b;
        endcase
    end

    // N and V only move on ADD and SUB
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            flags <= '0;
        end else if (flag_write) begin
            flags[FLAG_Z] <= (result == '0);
            if (kind_arith) begin
                flags[FLAG_N] <= result[15];
                flags[FLAG_V] <= sat;
            end
        end
    end

endmodule

/* cpu_data_mem.sv */
`timescale 1ns/1ps

module cpu_data_mem import cpu_pkg::*; #(
    parameter int DMEM_AW = 8
) (
    input  logic  clk,
    input  logic  arst_n,
    input  word_t addr,
    input  word_t wr_data,
    input  logic  write,
    output word_t rd_data
);

    logic [DMEM_AW-1:0] word_addr;
    word_t              mem [2**DMEM_AW];

    // Byte address, word aligned
    assign word_addr = addr[DMEM_AW:1];

    assign rd_data = mem[word_addr];

    always_ff @(posedge clk) begin
        if (write && arst_n) begin
            mem[word_addr] <= wr_data;
        end
    end

    // The decoder is expected to hold the write request low through reset
    a_no_wr_in_reset: assert property (
        @(posedge clk) !arst_n |-> !write
    ) else $error("data memory write requested during reset");

endmodule

/* cpu.sv */
`timescale 1ns/1ps

module cpu import cpu_pkg::*; #(
    parameter int DMEM_AW = 8
) (
    input  logic      clk,
    input  logic      arst_n,
    input  word_t     instr,
    output word_t     pc,
    output logic      hlt,
    output logic      wb_en,
    output reg_addr_t wb_reg,
    output word_t     wb_data
);

    word_t     pc_plus2;
    word_t     src_a;
    word_t     src_b;
    word_t     imm;
    alu_op_t   alu_op;
    logic      alu_use_imm;
    logic      flag_write;
    logic      kind_arith;
    logic      mem_read;
    logic      mem_write;
    logic      reg_write;
    logic      wb_from_pc;
    reg_addr_t dst;
    word_t     alu_a;
    word_t     alu_b;
    word_t     alu_result;
    flags_t    flags;
    word_t     mem_rd_data;

    cpu_fetch i_fetch (
        .clk       (clk),
        .arst_n    (arst_n),
        .instr     (instr),
        .flags     (flags),
        .br_target (src_a),
        .pc        (pc),
        .pc_plus2  (pc_plus2),
        .hlt       (hlt)
    );

    cpu_decode i_decode (
        .clk         (clk),
        .arst_n      (arst_n),
        .instr       (instr),
        .wr_data     (wb_data),
        .src_a       (src_a),
        .src_b       (src_b),
        .imm         (imm),
        .alu_op      (alu_op),
        .alu_use_imm (alu_use_imm),
        .flag_write  (flag_write),
        .mem_read    (mem_read),
        .mem_write   (mem_write),
        .reg_write   (reg_write),
        .wb_from_pc  (wb_from_pc),
        .dst         (dst)
    );

    // Memory base drops bit 0 of rs
    assign alu_a = (mem_read || mem_write) ? {src_a[15:1], 1'b0} : src_a;
    assign alu_b = alu_use_imm ? imm : src_b;
    assign kind_arith = flag_write && (alu_op == ALU_ADD || alu_op == ALU_SUB);

    cpu_alu i_alu (
        .clk        (clk),
        .arst_n     (arst_n),
        .a          (alu_a),
        .b          (alu_b),
        .op         (alu_op),
        .flag_write (flag_write),
        .kind_arith (kind_arith),
        .result     (alu_result),
        .flags      (flags)
    );

    cpu_data_mem #(
        .DMEM_AW (DMEM_AW)
    ) i_data_mem (
        .clk     (clk),
        .arst_n  (arst_n),
        .addr    (alu_result),
        .wr_data (src_b),
        .write   (mem_write),
        .rd_data (mem_rd_data)
    );

    // Writeback select
    assign wb_data = wb_from_pc ? pc_plus2 : (mem_read ? mem_rd_data : alu_result);
    assign wb_reg  = dst;
    assign wb_en   = reg_write && !hlt;

endmodule

/* tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD        = 20,
    parameter int RESET_CYCLES  = 16,
    parameter int RELEASE_DELAY = 2
) (
    input  logic restart,
    output logic clk,
    output logic arst_n
);

    initial clk = 1'b0;
    always #(PERIOD / 2) clk = ~clk;

    // Reset at time zero and again on every restart request
    initial begin
        forever begin
            arst_n = 1'b0;
            repeat (RESET_CYCLES) @(posedge clk);
            #(RELEASE_DELAY);
            arst_n = 1'b1;
            @(posedge restart);
        end
    end

endmodule

/* tb_cpu.sv */
`timescale 1ns/1ps

module tb_cpu import cpu_pkg::*; ;

    localparam int          CLK_PERIOD   = 20;
    localparam int          RESET_CYCLES = 16;
    localparam int          DRIVE_DELAY  = 2;
    localparam int          DMEM_AW      = 8;
    localparam int          PROG_LEN     = 400;
    localparam int          HALT_CYCLES  = 8;
    localparam int          NUM_PROGS    = 2;
    localparam logic [31:0] SEED         = 32'hf09bdf8b;
    // Budget of 420 cycles per program, doubled, plus both resets
    localparam int RUN_LIMIT = NUM_PROGS * (420 * CLK_PERIOD * 2 + RESET_CYCLES * CLK_PERIOD);

    logic      clk;
    logic      arst_n;
    logic      restart;
    word_t     instr;
    word_t     pc;
    logic      hlt;
    logic      wb_en;
    reg_addr_t wb_reg;
    word_t     wb_data;

    // Reference model state
    word_t m_regs [16];
    word_t m_mem [2**DMEM_AW];
    bit    m_valid [2**DMEM_AW];
    word_t m_pc;
    logic  m_n;
    logic  m_v;
    logic  m_z;

    int n_checks = 0;
    int n_errors = 0;

    tb_clock_gen #(
        .PERIOD        (CLK_PERIOD),
        .RESET_CYCLES  (RESET_CYCLES),
        .RELEASE_DELAY (DRIVE_DELAY)
    ) i_clock_gen (
        .restart (restart),
        .clk     (clk),
        .arst_n  (arst_n)
    );

    cpu #(
        .DMEM_AW (DMEM_AW)
    ) i_dut (
        .clk     (clk),
        .arst_n  (arst_n),
        .instr   (instr),
        .pc      (pc),
        .hlt     (hlt),
        .wb_en   (wb_en),
        .wb_reg  (wb_reg),
        .wb_data (wb_data)
    );

    task automatic check_word(input word_t got, input word_t exp, input string what);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("Error: time %0t ns, %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_reg(input reg_addr_t got, input reg_addr_t exp, input string what);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("Error: time %0t ns, %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("Error: time %0t ns, %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    function automatic logic cond_taken(input cond_t c);
        case (c)
            C_NE:    return !m_z;
            C_EQ:    return m_z;
            C_GT:    return !m_z && !m_n;
            C_LT:    return m_n;
            C_GE:    return m_z || !m_n;
            C_LE:    return m_n || m_z;
            C_OV:    return m_v;
            default: return 1'b1;
        endcase
    endfunction

    function automatic word_t saturate(input int s);
        if (s > 32767) begin
            return 16'h7FFF;
        end
        if (s < -32768) begin
            return 16'h8000;
        end
        return s[15:0];
    endfunction

    // LW and SW byte address is rs with bit 0 cleared plus twice the signed offset
    function automatic word_t mem_addr(input word_t w);
        word_t base;
        base = m_regs[w[7:4]];
        return {base[15:1], 1'b0} + {{11{w[3]}}, w[3:0], 1'b0};
    endfunction

    // Random instruction steered by the model so that the program moves forward
    function automatic word_t pick_instr();
        logic [31:0] r;
        opcode_t     op;
        word_t       w;
        word_t       addr;
        r  = $urandom;
        op = r[19:16] % 4'd15;
        w  = {op, r[11:0]};
        case (op)
            OP_B: w[8:0] = {4'b0000, r[24:20]};
            OP_BR: begin
                if (m_regs[w[7:4]][0] || m_regs[w[7:4]] <= m_pc) begin
                    w[15:12] = OP_LLB;
                end
            end
            OP_LW: begin
                // Only load words that were stored before
                addr = mem_addr(w);
                if (!m_valid[addr[DMEM_AW:1]]) begin
                    w[15:12] = OP_SW;
                end
            end
            default: begin
            end
        endcase
        return w;
    endfunction

    task automatic model_reset();
        m_pc = '0;
        m_n  = 1'b0;
        m_v  = 1'b0;
        m_z  = 1'b0;
        for (int i = 0; i < 16; i++) begin
            m_regs[i] = '0;
        end
    endtask

    task automatic model_step(input word_t w, output logic e_wb_en, output word_t e_data,
                              output logic e_hlt);
        opcode_t    op;
        reg_addr_t  rd;
        word_t      a;
        word_t      b;
        word_t      res;
        word_t      addr;
        word_t      next_pc;
        logic [3:0] sh;
        int         s;
        op      = w[15:12];
        rd      = w[11:8];
        a       = m_regs[w[7:4]];
        b       = m_regs[w[3:0]];
        sh      = w[3:0];
        res     = '0;
        e_wb_en = 1'b0;
        e_hlt   = 1'b0;
        next_pc = m_pc + 16'd2;
        case (op)
            OP_ADD, OP_SUB: begin
                if (op == OP_ADD) begin
                    s = int'($signed(a)) + int'($signed(b));
                end else begin
                    s = int'($signed(a)) - int'($signed(b));
                end
                res     = saturate(s);
                m_n     = res[15];
                m_v     = (s > 32767) || (s < -32768);
                m_z     = (res == 16'h0000);
                e_wb_en = 1'b1;
            end
            OP_XOR, OP_SLL, OP_SRA, OP_ROR: begin
                case (op)
                    OP_XOR:  res = a ^ b;
                    OP_SLL:  res = a << sh;
                    // Logical shift with the vacated top bits filled from the sign
                    OP_SRA:  res = (a >> sh) | ({16{a[15]}} & ~(16'hFFFF >> sh));
                    default: res = (a >> sh) | (a << (16 - sh));
                endcase
                m_z     = (res == 16'h0000);
                e_wb_en = 1'b1;
            end
            OP_LW: begin
                addr    = mem_addr(w);
                res     = m_mem[addr[DMEM_AW:1]];
                e_wb_en = 1'b1;
            end
            OP_SW: begin
                addr = mem_addr(w);
                m_mem[addr[DMEM_AW:1]]   = m_regs[rd];
                m_valid[addr[DMEM_AW:1]] = 1'b1;
            end
            OP_LLB: begin
                res     = {m_regs[rd][15:8], w[7:0]};
                e_wb_en = 1'b1;
            end
            OP_LHB: begin
                res     = {w[7:0], m_regs[rd][7:0]};
                e_wb_en = 1'b1;
            end
            OP_B: begin
                if (cond_taken(w[11:9])) begin
                    next_pc = m_pc + 16'd2 + {{6{w[8]}}, w[8:0], 1'b0};
                end
            end
            OP_BR: begin
                if (cond_taken(w[11:9])) begin
                    next_pc = a;
                end
            end
            OP_PCS: begin
                res     = m_pc + 16'd2;
                e_wb_en = 1'b1;
            end
            OP_HLT: begin
                e_hlt   = 1'b1;
                next_pc = m_pc;
            end
            // Opcodes 3 and 7 do nothing
            default: begin
            end
        endcase
        if (e_wb_en) begin
            m_regs[rd] = res;
        end
        e_data = res;
        m_pc   = next_pc;
    endtask

    // Returns at the release of reset, which falls on the drive time after an edge
    task automatic wait_reset();
        logic [31:0] r;
        while (arst_n !== 1'b1) begin
            // Register and memory writing opcodes that must have no effect in reset
            r     = $urandom;
            instr = {(r[12] ? OP_SW : OP_ADD), r[11:0]};
            @(negedge clk or posedge arst_n);
            if (arst_n === 1'b0) begin
                check_word(pc, 16'h0000, "pc in reset");
                check_bit(wb_en, 1'b0, "wb_en in reset");
                @(posedge clk);
                #(DRIVE_DELAY);
            end
        end
    endtask

    task automatic run_program();
        word_t w;
        logic  e_wb_en;
        word_t e_data;
        logic  e_hlt;
        for (int n = 0; n < PROG_LEN + HALT_CYCLES; n++) begin
            if (n < PROG_LEN) begin
                w = pick_instr();
            end else begin
                w = {OP_HLT, n[11:0]};
            end
            instr = w;
            @(negedge clk);
            check_word(pc, m_pc, "pc");
            model_step(w, e_wb_en, e_data, e_hlt);
            check_bit(hlt, e_hlt, "hlt");
            check_bit(wb_en, e_wb_en, "wb_en");
            if (e_wb_en) begin
                check_reg(wb_reg, w[11:8], "wb_reg");
                check_word(wb_data, e_data, "wb_data");
            end
            @(posedge clk);
            #(DRIVE_DELAY);
        end
    endtask

    initial begin
        #(RUN_LIMIT);
        $display("Timeout: the run did not finish within %0d ns", RUN_LIMIT);
        $display("Result: FAILED");
        $finish;
    end

    initial begin
        instr   = '0;
        restart = 1'b0;
        void'($urandom(SEED));
        model_reset();
        wait_reset();
        run_program();
        // Second program after a fresh reset with the data memory contents kept
        restart = 1'b1;
        wait (arst_n === 1'b0);
        restart = 1'b0;
        model_reset();
        wait_reset();
        run_program();
        $display("Checks: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

/* project.f */
cpu_pkg.sv
cpu_fetch.sv
cpu_decode.sv
cpu_alu.sv
cpu_data_mem.sv
cpu.sv
tb_clock_gen.sv
tb_cpu.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps -f project.f \
		--top-module tb_cpu -Mdir obj_dir
	./obj_dir/Vtb_cpu | tee /dev/stderr | grep -q "Result: PASSED"

clean:
	rm -rf obj_dir
